//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = cpuTb
FILELIST   = build.f
OBJDIR     = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- build.f
+incdir+hw
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/aluUnit.sv
hw/controller.sv
hw/datapath.sv
hw/memIo.sv
hw/finalCpu.sv
test/clockGen.sv
test/cpuTb.sv

//--- hw/aluUnit.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module aluUnit (
	input  logic [`DATA_WIDTH-1:0] a,
	input  logic [`DATA_WIDTH-1:0] b,
	input  ctrlPkg::aluOpT         op,
	output logic [`DATA_WIDTH-1:0] result,
	output isaPkg::flagsT          flagsOut
);
	import ctrlPkg::*;

	localparam int MSB = `DATA_WIDTH - 1;

	logic [`DATA_WIDTH:0] sumExt;  // extra bit is carry
	logic [`DATA_WIDTH:0] diffExt; // extra bit is borrow
	logic                 addOv;
	logic                 subOv;

	assign sumExt  = {1'b0, a} + {1'b0, b};
	assign diffExt = {1'b0, a} - {1'b0, b};

	// same sign in, other sign out
	assign addOv = (a[MSB] == b[MSB]) && (sumExt[MSB] != a[MSB]);
	assign subOv = (a[MSB] != b[MSB]) && (diffExt[MSB] != a[MSB]);

	always_comb begin
		case (op)
			ALU_ADD:  result = sumExt[MSB:0];
			ALU_SUB:  result = diffExt[MSB:0];
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_PASS: result = b;
			default:  result = sumExt[MSB:0];
		endcase
	end

	always_comb begin
		if (op == ALU_ADD) begin
			flagsOut.c = sumExt[`DATA_WIDTH];
			flagsOut.f = addOv;
		end else begin
			flagsOut.c = diffExt[`DATA_WIDTH];
			flagsOut.f = subOv;
		end
		// compare flags come off a - b
		flagsOut.l = diffExt[`DATA_WIDTH];
		flagsOut.n = diffExt[MSB] ^ subOv;
		flagsOut.z = (diffExt[MSB:0] == '0);
	end

endmodule

`default_nettype wire

//--- hw/controller.sv
`timescale 1ns/100ps
`default_nettype none

module controller (
	input  logic          clk,
	input  logic          rst,
	input  isaPkg::instrT instr,
	input  isaPkg::flagsT flags,
	output ctrlPkg::ctrlT ctrl
);
	import isaPkg::*;
	import ctrlPkg::*;

	stateT state;
	stateT stateNext;
	extT   aluCode;   // shared code for reg and imm forms
	aluOpT aluOpDec;
	logic  aluValid;
	logic  immSigned;
	logic  setsCf;
	logic  isCmp;

	function automatic logic condMet(input logic [3:0] cond, input flagsT fl);
		case (cond)
			COND_EQ: condMet = fl.z;
			COND_NE: condMet = !fl.z;
			COND_CS: condMet = fl.c;
			COND_CC: condMet = !fl.c;
			COND_LT: condMet = fl.n;
			COND_GE: condMet = !fl.n;
			COND_LO: condMet = fl.l;
			COND_HS: condMet = !fl.l;
			COND_AL: condMet = 1'b1;
			default: condMet = 1'b0; // reserved codes fall through
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (rst) state <= FETCH;
		else     state <= stateNext;
	end

	// immediate opcodes reuse the ext encoding
	assign aluCode = (instr.op == OP_REG) ? instr.ext : extT'(instr.op);

	always_comb begin
		aluValid  = 1'b1;
		aluOpDec  = ALU_ADD;
		immSigned = 1'b0; // logic imms and movi zero extend
		setsCf    = 1'b0;
		isCmp     = 1'b0;
		case (aluCode)
			EXT_ADD: begin
				setsCf    = 1'b1;
				immSigned = 1'b1;
			end
			EXT_SUB: begin
				aluOpDec  = ALU_SUB;
				setsCf    = 1'b1;
				immSigned = 1'b1;
			end
			EXT_CMP: begin
				aluOpDec  = ALU_SUB; // result dropped
				isCmp     = 1'b1;
				immSigned = 1'b1;
			end
			EXT_AND: aluOpDec = ALU_AND;
			EXT_OR:  aluOpDec = ALU_OR;
			EXT_XOR: aluOpDec = ALU_XOR;
			EXT_MOV: aluOpDec = ALU_PASS;
			default: aluValid = 1'b0; // mem, branch or unused code
		endcase
	end

	always_comb begin
		ctrl       = '0;
		ctrl.aSel  = A_REG;
		ctrl.bSel  = B_REG;
		ctrl.wbSel = WB_ALU;
		ctrl.pcSel = PC_INC;
		ctrl.aluOp = ALU_ADD;
		stateNext  = FETCH;
		case (state)
			FETCH: begin
				ctrl.instrWrite = 1'b1;
				ctrl.pcWrite    = 1'b1; // pc+1 from here on
				stateNext       = DECODE;
			end
			DECODE: stateNext = EXEC; // operands latched in datapath
			EXEC: begin
				if (instr.op == OP_MEM) begin
					stateNext = MEM; // address on port 2 this cycle
				end else if (instr.op == OP_BRANCH) begin
					if (condMet(instr.rDest, flags)) begin
						ctrl.pcWrite = 1'b1;
						ctrl.pcSel   = PC_BRANCH;
						ctrl.aSel    = A_PC;    // pc+1 plus disp
						ctrl.bSel    = B_SEXT;
					end
				end else if (aluValid) begin
					ctrl.aluOp    = aluOpDec;
					ctrl.regWrite = !isCmp;
					ctrl.psrWrite = setsCf || isCmp;
					ctrl.setZnl   = isCmp;
					if (instr.op != OP_REG)
						ctrl.bSel = immSigned ? B_SEXT : B_ZEXT;
				end
			end
			MEM: begin
				ctrl.wbSel    = WB_MEM;
				ctrl.regWrite = (instr.ext == EXT_LOAD);
				ctrl.memWrite = (instr.ext == EXT_STOR);
			end
			default: stateNext = FETCH;
		endcase
	end

	// store only in MEM of a memory op whose instruction is still held from EXEC
	memWriteInMem: assert property (@(posedge clk) disable iff (rst)
		ctrl.memWrite |-> (state == MEM && instr.op == OP_MEM && $stable(instr)));

	// no unknown state or control word once out of reset
	stateLegal: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(state) && !$isunknown(ctrl));

endmodule

`default_nettype wire

//--- hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// word size of registers, ALU and memory
`define DATA_WIDTH 16

// unified program and data store
`define MEM_DEPTH 1024
`define ADDR_WIDTH $clog2(`MEM_DEPTH) // 10 bit word address

// general purpose registers, r0 included
`define REG_COUNT 16

// board switches and leds
`define IO_WIDTH 10

// top word of memory is the io window
// load returns switches, store drives leds
`define IO_ADDR 10'h3FF

`endif

//--- hw/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	// multicycle sequence, every instruction enters at FETCH
	typedef enum logic [1:0] {FETCH, DECODE, EXEC, MEM} stateT;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,  // also cmp
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS  // b straight through for mov
	} aluOpT;

	typedef enum logic {A_REG, A_PC} aSelT;              // pc only for branch target
	typedef enum logic [1:0] {B_REG, B_SEXT, B_ZEXT} bSelT;
	typedef enum logic {WB_ALU, WB_MEM} wbSelT;
	typedef enum logic {PC_INC, PC_BRANCH} pcSelT;

	// control word from controller to datapath
	typedef struct packed {
		logic  regWrite;
		logic  psrWrite;
		logic  pcWrite;
		logic  instrWrite;
		logic  memWrite;
		logic  setZnl;   // 1 updates l n z, 0 updates c f
		aSelT  aSel;
		bSelT  bSel;
		wbSelT wbSel;
		pcSelT pcSel;
		aluOpT aluOp;
	} ctrlT;

endpackage

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module datapath (
	input  logic                   clk,
	input  logic                   rst,
	input  ctrlPkg::ctrlT          ctrl,
	input  logic [`DATA_WIDTH-1:0] rdata1,
	input  logic [`DATA_WIDTH-1:0] rdata2,
	output isaPkg::instrT          instr,
	output isaPkg::flagsT          flags,
	output logic [`ADDR_WIDTH-1:0] addr1,
	output logic [`ADDR_WIDTH-1:0] addr2,
	output logic [`DATA_WIDTH-1:0] wdata
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic [`ADDR_WIDTH-1:0] pc;
	logic [`ADDR_WIDTH-1:0] pcNext;
	logic [`ADDR_WIDTH-1:0] branchTarget;
	logic [`DATA_WIDTH-1:0] regFile [`REG_COUNT];
	logic [`DATA_WIDTH-1:0] regA;      // rDest operand
	logic [`DATA_WIDTH-1:0] regB;      // rSrc operand
	logic [7:0]             imm8;
	logic [`DATA_WIDTH-1:0] immSext;
	logic [`DATA_WIDTH-1:0] immZext;
	logic [`DATA_WIDTH-1:0] aluA;
	logic [`DATA_WIDTH-1:0] aluB;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic [`DATA_WIDTH-1:0] wbData;
	flagsT                  aluFlags;

	assign branchTarget = aluResult[`ADDR_WIDTH-1:0]; // adder reused for branches
	assign pcNext = (ctrl.pcSel == PC_BRANCH) ? branchTarget : pc + 1'b1;

	// fetch reads one cycle ahead, so a taken branch steers the port early
	assign addr1 = (ctrl.pcWrite && ctrl.pcSel == PC_BRANCH) ? branchTarget : pc;

	always_ff @(posedge clk) begin
		if (rst)               pc <= '0;
		else if (ctrl.pcWrite) pc <= pcNext;
	end

	always_ff @(posedge clk) begin
		if (ctrl.instrWrite) instr <= instrT'(rdata1);
	end

	// operand latches, stable from EXEC on
	always_ff @(posedge clk) begin
		regA <= regFile[instr.rDest];
		regB <= regFile[instr.rSrc];
	end

	assign imm8    = {instr.ext, instr.rSrc};
	assign immSext = {{(`DATA_WIDTH-8){imm8[7]}}, imm8};
	assign immZext = {{(`DATA_WIDTH-8){1'b0}}, imm8};

	assign aluA = (ctrl.aSel == A_PC) ? {{(`DATA_WIDTH-`ADDR_WIDTH){1'b0}}, pc} : regA;

	always_comb begin
		case (ctrl.bSel)
			B_SEXT:  aluB = immSext;
			B_ZEXT:  aluB = immZext;
			default: aluB = regB;
		endcase
	end

	aluUnit u_aluUnit (
		.a        (aluA),
		.b        (aluB),
		.op       (ctrl.aluOp),
		.result   (aluResult),
		.flagsOut (aluFlags)
	);

	assign wbData = (ctrl.wbSel == WB_MEM) ? rdata2 : aluResult;

	always_ff @(posedge clk) begin
		if (ctrl.regWrite) regFile[instr.rDest] <= wbData;
	end

	// cmp owns l n z, add and sub own c f
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (ctrl.psrWrite) begin
			if (ctrl.setZnl) begin
				flags.l <= aluFlags.l;
				flags.n <= aluFlags.n;
				flags.z <= aluFlags.z;
			end else begin
				flags.c <= aluFlags.c;
				flags.f <= aluFlags.f;
			end
		end
	end

	assign addr2 = regB[`ADDR_WIDTH-1:0]; // rSrc holds the address
	assign wdata = regA;                  // stor data from rDest

	fetchNotWriteback: assert property (@(posedge clk) disable iff (rst)
		(ctrl.pcWrite || ctrl.instrWrite) |-> !ctrl.regWrite);

endmodule

`default_nettype wire

//--- hw/finalCpu.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module finalCpu (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [`IO_WIDTH-1:0] switches,
	output logic [`IO_WIDTH-1:0] leds,
	output logic                 ledStrobe
);
	import isaPkg::*;
	import ctrlPkg::*;

	ctrlT                   ctrl;
	instrT                  instr;
	flagsT                  flags;
	logic [`ADDR_WIDTH-1:0] addr1;  // fetch
	logic [`ADDR_WIDTH-1:0] addr2;  // load / stor
	logic [`DATA_WIDTH-1:0] wdata;
	logic [`DATA_WIDTH-1:0] rdata1;
	logic [`DATA_WIDTH-1:0] rdata2;

	controller u_controller (
		.clk   (clk),
		.rst   (rst),
		.instr (instr),
		.flags (flags),
		.ctrl  (ctrl)
	);

	datapath u_datapath (
		.clk    (clk),
		.rst    (rst),
		.ctrl   (ctrl),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.instr  (instr),
		.flags  (flags),
		.addr1  (addr1),
		.addr2  (addr2),
		.wdata  (wdata)
	);

	memIo u_memIo (
		.clk       (clk),
		.rst       (rst),
		.addr1     (addr1),
		.addr2     (addr2),
		.wdata     (wdata),
		.memWrite  (ctrl.memWrite),
		.switches  (switches),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.leds      (leds),
		.ledStrobe (ledStrobe)
	);

endmodule

`default_nettype wire

//--- hw/isaPkg.sv
`default_nettype none

package isaPkg;

	// primary opcode, bits 15:12
	typedef enum logic [3:0] {
		OP_REG    = 4'b0000, // alu op picked by ext
		OP_ANDI   = 4'b0001,
		OP_ORI    = 4'b0010,
		OP_XORI   = 4'b0011,
		OP_MEM    = 4'b0100, // load / stor
		OP_ADDI   = 4'b0101,
		OP_SUBI   = 4'b1001,
		OP_CMPI   = 4'b1011,
		OP_BRANCH = 4'b1100,
		OP_MOVI   = 4'b1101
	} opT;

	// extended opcode, bits 7:4
	// arithmetic codes line up with the immediate opcodes
	typedef enum logic [3:0] {
		EXT_LOAD = 4'b0000,
		EXT_AND  = 4'b0001,
		EXT_OR   = 4'b0010,
		EXT_XOR  = 4'b0011,
		EXT_STOR = 4'b0100,
		EXT_ADD  = 4'b0101,
		EXT_SUB  = 4'b1001,
		EXT_CMP  = 4'b1011,
		EXT_MOV  = 4'b1101
	} extT;

	// branch condition sits in the rDest field
	typedef enum logic [3:0] {
		COND_EQ = 4'd0,
		COND_NE = 4'd1,
		COND_CS = 4'd2,
		COND_CC = 4'd3,
		COND_LT = 4'd4,
		COND_GE = 4'd5,
		COND_LO = 4'd6,
		COND_HS = 4'd7,
		COND_AL = 4'd14 // other codes never taken
	} condT;

	typedef struct packed {
		opT         op;
		logic [3:0] rDest;
		extT        ext;   // high nibble of imm8 / disp
		logic [3:0] rSrc;  // low nibble of imm8 / disp
	} instrT;

	// processor status register
	typedef struct packed {
		logic c; // carry out, borrow on sub
		logic f; // signed overflow
		logic l; // unsigned less
		logic n; // signed less
		logic z; // equal
	} flagsT;

endpackage

`default_nettype wire

//--- hw/memIo.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module memIo (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`ADDR_WIDTH-1:0] addr1,
	input  logic [`ADDR_WIDTH-1:0] addr2,
	input  logic [`DATA_WIDTH-1:0] wdata,
	input  logic                   memWrite,
	input  logic [`IO_WIDTH-1:0]   switches,
	output logic [`DATA_WIDTH-1:0] rdata1,
	output logic [`DATA_WIDTH-1:0] rdata2,
	output logic [`IO_WIDTH-1:0]   leds,
	output logic                   ledStrobe
);
	logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH]; // program and data
	logic                   ioSel;

	assign ioSel = (addr2 == `IO_ADDR);

	// port 1 is fetch only
	always_ff @(posedge clk) begin
		rdata1 <= mem[addr1];
	end

	// port 2 for load and stor, io word decoded out of the array
	always_ff @(posedge clk) begin
		if (ioSel) rdata2 <= {{(`DATA_WIDTH-`IO_WIDTH){1'b0}}, switches};
		else       rdata2 <= mem[addr2];
		if (memWrite && !ioSel)
			mem[addr2] <= wdata;
	end

	assign ledStrobe = memWrite && ioSel; // high for the MEM cycle only

	always_ff @(posedge clk) begin
		if (rst)            leds <= '0;
		else if (ledStrobe) leds <= wdata[`IO_WIDTH-1:0]; // visible next cycle
	end

endmodule

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
	parameter int PERIOD       = 4,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0; // released on an edge like other stimulus
	end

endmodule

`default_nettype wire

//--- test/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module cpuTb;
	import isaPkg::*;

	localparam int PROG_LEN        = 400;
	localparam int END_ADDR        = PROG_LEN - 1; // branch-to-self
	localparam int CLK_PERIOD      = 4;
	localparam int WATCHDOG_CYCLES = PROG_LEN * 4 + 200;
	localparam int IO_GAP          = 5;  // random instrs between io stores
	localparam int NOP_RUN         = 4;  // switches move only here
	localparam int SW_SLOTS        = 512;

	logic                 clk;
	logic                 rst;
	logic [`IO_WIDTH-1:0] switches = '0;
	logic [`IO_WIDTH-1:0] leds;
	logic                 ledStrobe;

	logic [`DATA_WIDTH-1:0] prog [PROG_LEN];
	logic [`DATA_WIDTH-1:0] mdlMem [`MEM_DEPTH];
	logic [`DATA_WIDTH-1:0] mdlRegs [`REG_COUNT];
	logic [`IO_WIDTH-1:0]   swVals [SW_SLOTS];   // value after n io stores
	logic [`IO_WIDTH-1:0]   expLeds [$];
	flagsT                  expFlags [$];
	logic [`IO_WIDTH-1:0]   ledsWant;
	flagsT                  flagsWant;
	int                     idx;
	int                     strobesSeen = 0;
	int                     swIdx = 0;
	bit                     swPending = 0;
	bit                     ledsCheckDue = 0;
	bit                     prevStrobe = 0;

	extT aluExts [7] = '{EXT_ADD, EXT_SUB, EXT_AND, EXT_OR, EXT_XOR, EXT_CMP, EXT_MOV};
	opT  immOps  [7] = '{OP_ADDI, OP_SUBI, OP_ANDI, OP_ORI, OP_XORI, OP_CMPI, OP_MOVI};

	clockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clockGen (
		.clk (clk),
		.rst (rst)
	);

	finalCpu u_finalCpu (
		.clk       (clk),
		.rst       (rst),
		.switches  (switches),
		.leds      (leds),
		.ledStrobe (ledStrobe)
	);

	function automatic logic [15:0] encImm(input opT op, input logic [3:0] d,
		input logic [7:0] imm);
		encImm = {op, d, imm};
	endfunction

	function automatic logic [15:0] encReg(input logic [3:0] op, input extT e,
		input logic [3:0] d, input logic [3:0] s);
		encReg = {op, d, e, s}; // reg form and mem form share the layout
	endfunction

	function automatic logic [15:0] fillWord(input logic [9:0] a);
		fillWord = {a[5:0], a} ^ 16'hc3a5;
	endfunction

	function automatic logic branchTaken(input logic [3:0] cond, input flagsT fl);
		case (cond)
			4'd0:    branchTaken = fl.z;
			4'd1:    branchTaken = !fl.z;
			4'd2:    branchTaken = fl.c;
			4'd3:    branchTaken = !fl.c;
			4'd4:    branchTaken = fl.n;
			4'd5:    branchTaken = !fl.n;
			4'd6:    branchTaken = fl.l;
			4'd7:    branchTaken = !fl.l;
			4'd14:   branchTaken = 1'b1;
			default: branchTaken = 1'b0;
		endcase
	endfunction

	task automatic emit(input logic [15:0] w);
		prog[idx] = w;
		idx++;
	endtask

	task automatic emitIoStore(input logic [3:0] r);
		emit(encReg(OP_MEM, EXT_STOR, r, 4'd15)); // r15 holds the io address
		repeat (NOP_RUN) emit(encReg(OP_REG, EXT_MOV, 4'd0, 4'd0));
	endtask

	task automatic buildProgram();
		int sinceIo;
		logic [3:0] rd;
		idx = 0;
		sinceIo = 0;
		for (int r = 0; r < 13; r++)
			emit(encImm(OP_MOVI, 4'(r), 8'($urandom)));
		emit(encImm(OP_MOVI, 4'd13, 8'h00));
		emit(encImm(OP_SUBI, 4'd13, 8'h20)); // data word 0x3e0
		emit(encImm(OP_MOVI, 4'd14, 8'h00));
		emit(encImm(OP_SUBI, 4'd14, 8'h10)); // data word 0x3f0
		emit(encImm(OP_MOVI, 4'd15, 8'h00));
		emit(encImm(OP_SUBI, 4'd15, 8'h01)); // low 10 bits hit the io word
		while (idx < END_ADDR - 12) begin
			rd = 4'($urandom_range(0, 12));
			if (sinceIo >= IO_GAP) begin
				emitIoStore(4'($urandom_range(0, 15)));
				sinceIo = 0;
			end else begin
				case ($urandom_range(0, 9))
					0, 1, 2: emit(encReg(OP_REG, aluExts[$urandom_range(0, 6)], rd,
						4'($urandom_range(0, 15))));
					3, 4, 5: emit(encImm(immOps[$urandom_range(0, 6)], rd, 8'($urandom)));
					6, 7: emit({OP_BRANCH, 4'($urandom), 8'($urandom_range(0, 6))});
					8: begin
						emit(encReg(OP_MEM, EXT_STOR, 4'($urandom_range(0, 15)),
							$urandom_range(0, 1) ? 4'd13 : 4'd14));
						emit(encReg(OP_MEM, EXT_LOAD, rd,
							$urandom_range(0, 1) ? 4'd13 : 4'd14));
						emitIoStore(rd);
					end
					default: begin
						emit(encReg(OP_MEM, EXT_LOAD, rd, 4'd15)); // reads switches
						emitIoStore(rd);
					end
				endcase
				sinceIo++;
			end
		end
		while (idx < END_ADDR)
			emit(encReg(OP_REG, EXT_MOV, 4'd0, 4'd0));
		emit({OP_BRANCH, 4'd14, 8'hff}); // pc+1-1 loops here
	endtask

	// instruction-set model that queues every io store
	task automatic runModel();
		logic [9:0]  pcM;
		logic [15:0] ir;
		logic [3:0]  op;
		logic [3:0]  d;
		logic [3:0]  code;
		logic [15:0] sx;
		logic [15:0] a;
		logic [15:0] b;
		logic [16:0] full;
		logic [9:0]  addr;
		flagsT       fl;
		int          wide;
		int          ioCount;
		int          steps;
		pcM = '0;
		fl = '0;
		ioCount = 0;
		steps = 0;
		while (pcM != 10'(END_ADDR) && steps < 2 * PROG_LEN) begin
			ir = mdlMem[pcM];
			pcM = pcM + 1'b1;
			steps++;
			op = ir[15:12];
			d = ir[11:8];
			sx = {{8{ir[7]}}, ir[7:0]};
			a = mdlRegs[d];
			if (op == OP_BRANCH) begin
				if (branchTaken(d, fl)) pcM = pcM + sx[9:0];
			end else if (op == OP_MEM) begin
				addr = mdlRegs[ir[3:0]][9:0];
				if (ir[7:4] == EXT_LOAD) begin
					mdlRegs[d] = (addr == `IO_ADDR) ? 16'(swVals[ioCount]) : mdlMem[addr];
				end else if (addr == `IO_ADDR) begin
					expLeds.push_back(a[`IO_WIDTH-1:0]);
					expFlags.push_back(fl);
					ioCount++;
				end else begin
					mdlMem[addr] = a;
				end
			end else begin
				code = (op == OP_REG) ? ir[7:4] : op;
				if (op == OP_REG) b = mdlRegs[ir[3:0]];
				else if (code inside {EXT_ADD, EXT_SUB, EXT_CMP}) b = sx;
				else b = {8'h00, ir[7:0]}; // logic imms and movi
				case (code)
					EXT_ADD: begin
						full = {1'b0, a} + {1'b0, b};
						wide = int'($signed(a)) + int'($signed(b));
						fl.c = full[16];
						fl.f = (wide > 32767) || (wide < -32768);
						mdlRegs[d] = full[15:0];
					end
					EXT_SUB: begin
						wide = int'($signed(a)) - int'($signed(b));
						fl.c = (a < b); // borrow
						fl.f = (wide > 32767) || (wide < -32768);
						mdlRegs[d] = a - b;
					end
					EXT_CMP: begin
						fl.l = (a < b);
						fl.n = ($signed(a) < $signed(b));
						fl.z = (a == b);
					end
					EXT_AND: mdlRegs[d] = a & b;
					EXT_OR:  mdlRegs[d] = a | b;
					EXT_XOR: mdlRegs[d] = a ^ b;
					default: mdlRegs[d] = b; // mov
				endcase
			end
		end
	endtask

	task automatic abortRun();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkLeds(input logic [`IO_WIDTH-1:0] want,
		input logic [`IO_WIDTH-1:0] got);
		if (got !== want) begin
			$display("Error at %0t: leds expected %h, got %h", $time, want, got);
			abortRun();
		end
	endtask

	task automatic checkFlags(input flagsT want, input flagsT got);
		if (got !== want) begin
			$display("Error at %0t: flags expected %b, got %b", $time, want, got);
			abortRun();
		end
	endtask

	always @(posedge clk) begin
		if (swPending) begin
			switches <= swVals[swIdx];
			swPending = 0;
		end
	end

	// sampled mid-cycle where outputs have settled
	always @(negedge clk) begin
		if (!rst) begin
			if (ledsCheckDue) begin
				checkLeds(ledsWant, leds);
				ledsCheckDue = 0;
			end else if (strobesSeen == 0) begin
				checkLeds('0, leds); // dark until first store
			end
			if (ledStrobe && prevStrobe) begin
				$display("ledStrobe stayed high for more than one cycle at %0t", $time);
				abortRun();
			end else if (ledStrobe) begin
				if (expLeds.size() == 0) begin
					$display("LED write at %0t with no io store left in the model", $time);
					abortRun();
				end else begin
					ledsWant = expLeds.pop_front();
					flagsWant = expFlags.pop_front();
					checkFlags(flagsWant, u_finalCpu.flags);
					ledsCheckDue = 1;
					strobesSeen++;
					swIdx = strobesSeen; // new switches inside the nop run
					swPending = 1;
				end
			end
			prevStrobe = ledStrobe;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, the program did not finish its LED writes in time");
		abortRun();
	end

	initial begin
		void'($urandom(32'h0ab156f4));
		buildProgram();
		for (int i = 0; i < SW_SLOTS; i++)
			swVals[i] = `IO_WIDTH'($urandom);
		swPending = 1;
		for (int i = 0; i < `MEM_DEPTH; i++)
			mdlMem[i] = (i < PROG_LEN) ? prog[i] : fillWord(10'(i));
		#1; // reset is high here
		for (int i = 0; i < `MEM_DEPTH; i++)
			u_finalCpu.u_memIo.mem[i] = mdlMem[i];
		runModel();
		@(negedge rst);
		while (expLeds.size() != 0) @(negedge clk);
		repeat (40) @(negedge clk); // catch stray strobes
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire
